// ==== softmax_pkg.sv ====
// Softmax fixed-point constants, element and sum types, pass enumeration, exp and ln functions
package softmax_pkg;

    localparam int FRAC_BITS = 16;
    localparam int ELEM_W    = 32;
    localparam int SUM_W     = ELEM_W + 16;   // Headroom for the exp sum

    typedef logic signed [ELEM_W-1:0] elem_t;  // Q16.16
    typedef logic [SUM_W-1:0]         sum_t;

    localparam elem_t ONE_Q   = 32'sh0001_0000;
    localparam elem_t LOG2E_Q = 32'sh0001_7154;  // ~1.442695
    localparam elem_t LN2_Q   = 32'sh0000_b172;  // ~0.693147

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        SUM,
        LN,
        OUT,
        DONE
    } pass_t;

    // exp(x) as 2^t, t = x*log2(e) split into integer n and fraction f
    function automatic elem_t exp_q(input elem_t x);
        logic signed [2*ELEM_W-1:0] prod;
        logic signed [2*ELEM_W-1:0] t;
        logic signed [2*ELEM_W-1:0] n;
        logic signed [2*ELEM_W-1:0] neg_n;
        logic [ELEM_W-1:0]          mant;
        prod  = x * LOG2E_Q;
        t     = prod >>> FRAC_BITS;
        n     = t >>> FRAC_BITS;                // Floor
        neg_n = -n;
        mant  = ONE_Q + {{(ELEM_W-FRAC_BITS){1'b0}}, t[FRAC_BITS-1:0]};  // 1 + f
        if (neg_n >= ELEM_W) begin
            exp_q = '0;                         // Underflow
        end else if (n >= 0) begin
            exp_q = elem_t'(mant << n[$clog2(ELEM_W)-1:0]);
        end else begin
            exp_q = elem_t'(mant >> neg_n[$clog2(ELEM_W)-1:0]);
        end
    endfunction

    // ln(s) = (log2 s) * ln 2, with log2 from leading-one position and mantissa
    function automatic elem_t ln_q(input sum_t s);
        int                         k;
        sum_t                       norm;
        elem_t                      lg;
        logic signed [2*ELEM_W-1:0] prod;
        k = 0;
        for (int i = 0; i < SUM_W; i++) begin
            if (s[i]) begin
                k = i;
            end
        end
        // Leading one moved to bit FRAC_BITS, bits below it become the fraction
        if (k >= FRAC_BITS) begin
            norm = s >> (k - FRAC_BITS);
        end else begin
            norm = s << (FRAC_BITS - k);
        end
        lg   = elem_t'(k - FRAC_BITS) <<< FRAC_BITS;
        lg   = lg + elem_t'({{(ELEM_W-FRAC_BITS){1'b0}}, norm[FRAC_BITS-1:0]});
        prod = lg * LN2_Q;
        ln_q = elem_t'(prod >>> FRAC_BITS);
    endfunction

endpackage

// ==== tile_stream_if.sv ====
// Lane-input and lane-result tile bundle with controller, lane and drain modports
`timescale 1ns/1ns

interface tile_stream_if
    import softmax_pkg::*;
#(
    parameter int TILE_SIZE = 8
);
    // Controller side, slot 0 holds element 0
    elem_t arg [TILE_SIZE];
    logic  arg_valid;
    pass_t arg_pass;                // SUM or OUT

    // Lane results, one cycle behind arg
    elem_t res [TILE_SIZE];
    logic  res_valid;               // Delayed arg_valid, driven by lane 0
    pass_t res_pass;                // Delayed arg_pass, driven by lane 0

    modport source (
        output arg, arg_valid, arg_pass
    );

    modport lane (
        input  arg, arg_valid, arg_pass,
        output res, res_valid, res_pass
    );

    modport sink (
        input res, res_valid, res_pass
    );

endinterface

// ==== softmax_ctrl.sv ====
// Softmax pass FSM, tile buffer, running max tracking and lane-input forming
`timescale 1ns/1ns

module softmax_ctrl
    import softmax_pkg::*;
#(
    parameter int TILE_SIZE      = 8,
    parameter int TOTAL_ELEMENTS = 64
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [TILE_SIZE*ELEM_W-1:0] x_tile,
    input  logic                        x_valid,
    input  logic                        ln_ready,
    input  elem_t                       ln_sum,
    input  logic                        out_done,
    tile_stream_if.source               lanes,
    output pass_t                       pass
);
    localparam int TILES  = TOTAL_ELEMENTS / TILE_SIZE;
    localparam int ADDR_W = (TILES > 1) ? $clog2(TILES) : 1;
    localparam int CNT_W  = $clog2(TILES + 1);       // Must also hold TILES
    localparam elem_t MOST_NEG = {1'b1, {(ELEM_W-1){1'b0}}};

    pass_t                       state;
    logic [CNT_W-1:0]            tile_cnt;
    logic                        last_tile;
    logic                        issue;
    logic [TILE_SIZE*ELEM_W-1:0] tile_buf [TILES];
    logic [TILE_SIZE*ELEM_W-1:0] rd_data;
    logic                        rd_valid;
    pass_t                       rd_pass;
    elem_t                       max_val;
    elem_t                       tile_max;
    elem_t                       bias;
    elem_t                       x_slot  [TILE_SIZE];
    elem_t                       rd_slot [TILE_SIZE];

    assign pass      = state;
    assign last_tile = (tile_cnt == CNT_W'(TILES - 1));
    assign issue     = (state == SUM) || (state == OUT && tile_cnt != CNT_W'(TILES));
    assign bias      = (rd_pass == OUT) ? ln_sum : '0;  // ln(sum) only in the output pass

    // Unpack tiles, element 0 sits in the top slot
    for (genvar i = 0; i < TILE_SIZE; i++) begin : g_slot
        assign x_slot[i]  = x_tile[(TILE_SIZE-1-i)*ELEM_W +: ELEM_W];
        assign rd_slot[i] = rd_data[(TILE_SIZE-1-i)*ELEM_W +: ELEM_W];
    end

    // Running max including the incoming tile
    always_comb begin
        tile_max = max_val;
        for (int i = 0; i < TILE_SIZE; i++) begin
            if (x_slot[i] > tile_max) begin
                tile_max = x_slot[i];
            end
        end
    end

    // Pass FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            tile_cnt <= '0;
            max_val  <= MOST_NEG;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        state    <= LOAD;
                        tile_cnt <= '0;
                        max_val  <= MOST_NEG;
                    end
                end
                LOAD: begin
                    if (x_valid) begin
                        max_val  <= tile_max;
                        tile_cnt <= tile_cnt + 1'b1;
                        if (last_tile) begin
                            state    <= SUM;
                            tile_cnt <= '0;
                        end
                    end
                end
                SUM: begin                      // One read per cycle
                    tile_cnt <= tile_cnt + 1'b1;
                    if (last_tile) begin
                        state    <= LN;
                        tile_cnt <= '0;
                    end
                end
                LN: begin
                    if (ln_ready) begin
                        state <= OUT;
                    end
                end
                OUT: begin
                    if (issue) begin
                        tile_cnt <= tile_cnt + 1'b1;
                    end
                    if (out_done) begin
                        state <= DONE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Tile buffer
    always_ff @(posedge clk) begin
        if (state == LOAD && x_valid) begin
            tile_buf[tile_cnt[ADDR_W-1:0]] <= x_tile;
        end
        if (issue) begin
            rd_data <= tile_buf[tile_cnt[ADDR_W-1:0]];
        end
    end

    // Valid and pass tags follow the read through the forming stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid        <= 1'b0;
            rd_pass         <= IDLE;
            lanes.arg_valid <= 1'b0;
            lanes.arg_pass  <= IDLE;
        end else begin
            rd_valid        <= issue;
            rd_pass         <= state;
            lanes.arg_valid <= rd_valid;
            lanes.arg_pass  <= rd_pass;
        end
    end

    // x - max, or x - max - ln(sum) in OUT
    always_ff @(posedge clk) begin
        for (int i = 0; i < TILE_SIZE; i++) begin
            lanes.arg[i] <= rd_slot[i] - max_val - bias;
        end
    end

endmodule

// ==== exp_lane.sv ====
// Single registered exp lane, lane 0 also carries the valid and pass tags
`timescale 1ns/1ns

module exp_lane
    import softmax_pkg::*;
#(
    parameter int LANE = 0
) (
    input  logic        clk,
    input  logic        rst_n,
    tile_stream_if.lane lane
);
    elem_t res_q;

    always_ff @(posedge clk) begin
        res_q <= exp_q(lane.arg[LANE]);  // One cycle of latency
    end

    assign lane.res[LANE] = res_q;

    // Tags travel with lane 0 only
    if (LANE == 0) begin : g_tag
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                lane.res_valid <= 1'b0;
                lane.res_pass  <= IDLE;
            end else begin
                lane.res_valid <= lane.arg_valid;
                lane.res_pass  <= lane.arg_pass;
            end
        end
    end

endmodule

// ==== softmax_drain.sv ====
// Exp sum accumulation, ln of the sum, output tile register and done flag
`timescale 1ns/1ns

module softmax_drain
    import softmax_pkg::*;
#(
    parameter int TILE_SIZE      = 8,
    parameter int TOTAL_ELEMENTS = 64
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  pass_t                       pass,
    tile_stream_if.sink                 lanes,
    output logic                        ln_ready,
    output elem_t                       ln_sum,
    output logic                        out_done,
    output logic [TILE_SIZE*ELEM_W-1:0] y_tile,
    output logic                        y_valid,
    output logic                        done
);
    localparam int TILES = TOTAL_ELEMENTS / TILE_SIZE;
    localparam int CNT_W = (TILES > 1) ? $clog2(TILES) : 1;

    sum_t             acc;
    sum_t             tile_sum;
    logic [CNT_W-1:0] sum_cnt;
    logic [CNT_W-1:0] out_cnt;
    logic             sum_last;        // Final SUM tile is in acc
    logic             sum_hit;
    logic             out_hit;

    assign sum_hit = lanes.res_valid && (lanes.res_pass == SUM);
    assign out_hit = lanes.res_valid && (lanes.res_pass == OUT);

    // Exp results are never negative
    always_comb begin
        tile_sum = '0;
        for (int i = 0; i < TILE_SIZE; i++) begin
            tile_sum = tile_sum + {{(SUM_W-ELEM_W){1'b0}}, lanes.res[i]};
        end
    end

    // Sum pass
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc      <= '0;
            sum_cnt  <= '0;
            sum_last <= 1'b0;
            ln_ready <= 1'b0;
        end else if (pass == LOAD) begin   // Fresh vector
            acc      <= '0;
            sum_cnt  <= '0;
            sum_last <= 1'b0;
            ln_ready <= 1'b0;
        end else begin
            sum_last <= 1'b0;
            if (sum_hit) begin
                acc      <= acc + tile_sum;
                sum_cnt  <= sum_cnt + 1'b1;
                sum_last <= (sum_cnt == CNT_W'(TILES - 1));
            end
            if (sum_last) begin
                ln_ready <= 1'b1;              // Held until the next LOAD
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sum_last) begin
            ln_sum <= ln_q(acc);
        end
    end

    // Output pass
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            y_valid  <= 1'b0;
            out_done <= 1'b0;
            out_cnt  <= '0;
            done     <= 1'b0;
        end else begin
            y_valid  <= out_hit;
            out_done <= 1'b0;
            if (pass == LOAD) begin
                out_cnt <= '0;
                done    <= 1'b0;
            end else if (out_hit) begin
                out_cnt  <= out_cnt + 1'b1;
                out_done <= (out_cnt == CNT_W'(TILES - 1));  // Pulses with the last tile
            end
            if (out_done) begin
                done <= 1'b1;
            end
        end
    end

    // Repack with element 0 in the top slot
    always_ff @(posedge clk) begin
        if (out_hit) begin
            for (int i = 0; i < TILE_SIZE; i++) begin
                y_tile[(TILE_SIZE-1-i)*ELEM_W +: ELEM_W] <= lanes.res[i];
            end
        end
    end

endmodule

// ==== softmax_top.sv ====
// Softmax top level with controller, exp lanes, drain and lane bundle
`timescale 1ns/1ns

module softmax_top
    import softmax_pkg::*;
#(
    parameter int TILE_SIZE      = 8,
    parameter int TOTAL_ELEMENTS = 64
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [TILE_SIZE*ELEM_W-1:0] x_tile,     // Element 0 in top slot
    input  logic                        x_valid,
    output logic [TILE_SIZE*ELEM_W-1:0] y_tile,
    output logic                        y_valid,
    output logic                        done
);
    pass_t pass;
    logic  ln_ready;
    elem_t ln_sum;
    logic  out_done;

    tile_stream_if #(.TILE_SIZE(TILE_SIZE)) lanes_if ();

    softmax_ctrl #(
        .TILE_SIZE      (TILE_SIZE),
        .TOTAL_ELEMENTS (TOTAL_ELEMENTS)
    ) u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .x_tile   (x_tile),
        .x_valid  (x_valid),
        .ln_ready (ln_ready),
        .ln_sum   (ln_sum),
        .out_done (out_done),
        .lanes    (lanes_if.source),
        .pass     (pass)
    );

    // One exp unit per tile slot
    for (genvar i = 0; i < TILE_SIZE; i++) begin : g_lane
        exp_lane #(.LANE(i)) u_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .lane  (lanes_if.lane)
        );
    end

    softmax_drain #(
        .TILE_SIZE      (TILE_SIZE),
        .TOTAL_ELEMENTS (TOTAL_ELEMENTS)
    ) u_drain (
        .clk      (clk),
        .rst_n    (rst_n),
        .pass     (pass),
        .lanes    (lanes_if.sink),
        .ln_ready (ln_ready),
        .ln_sum   (ln_sum),
        .out_done (out_done),
        .y_tile   (y_tile),
        .y_valid  (y_valid),
        .done     (done)
    );

endmodule

// ==== tb_softmax.sv ====
// Softmax testbench with clock, reset, random vectors, a reference model and checks
`timescale 1ns/1ns

module tb_softmax
    import softmax_pkg::*;
();
    localparam int TILE_SIZE      = 8;
    localparam int TOTAL_ELEMENTS = 64;
    localparam int TILES          = TOTAL_ELEMENTS / TILE_SIZE;
    localparam int NUM_TESTS      = 5;
    localparam int TIMEOUT_CYCLES = 4 * (NUM_TESTS * (3 * TILES + 20));

    // Vector kinds for build_vector
    localparam int KIND_RANDOM  = 0;    // Elements in +-8.0
    localparam int KIND_UNIFORM = 1;
    localparam int KIND_SPIKE   = 2;    // One element at 8.0, rest in +-1.0
    localparam int KIND_LOW     = 3;    // Elements in [-8.0, -4.0)

    typedef logic [TILE_SIZE*ELEM_W-1:0] tile_t;

    logic   clk;
    logic   rst_n;
    logic   start;
    tile_t  x_tile;
    logic   x_valid;
    tile_t  y_tile;
    logic   y_valid;
    logic   done;

    integer seed;
    int     cycles;
    int     err_cnt;
    int     tests_run;
    int     tests_failed;
    elem_t  vec   [TOTAL_ELEMENTS];
    elem_t  exp_y [TOTAL_ELEMENTS];   // Expected outputs from the model

    softmax_top uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .x_tile  (x_tile),
        .x_valid (x_valid),
        .y_tile  (y_tile),
        .y_valid (y_valid),
        .done    (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // 2^(x*log2 e) with the integer part applied as a shift of 1+f
    function automatic elem_t exp_ref(input elem_t x);
        longint t;
        longint n;
        longint f;
        longint mant;
        t    = (longint'(x) * longint'(LOG2E_Q)) >>> FRAC_BITS;
        n    = t >>> FRAC_BITS;
        f    = t & 64'hffff;
        mant = longint'(ONE_Q) + f;
        if (n <= -32) begin
            exp_ref = '0;
        end else if (n >= 0) begin
            exp_ref = elem_t'(mant << n);
        end else begin
            exp_ref = elem_t'(mant >> (-n));
        end
    endfunction

    function automatic elem_t ln_ref(input longint s);
        int     k;
        longint frac;
        longint lg;
        k = 0;
        while ((s >> (k + 1)) != 0) begin
            k++;                                    // Leading one position
        end
        if (k >= FRAC_BITS) begin
            frac = (s >> (k - FRAC_BITS)) & 64'hffff;
        end else begin
            frac = (s << (FRAC_BITS - k)) & 64'hffff;
        end
        lg     = (longint'(k - FRAC_BITS) << FRAC_BITS) + frac;
        ln_ref = elem_t'((lg * longint'(LN2_Q)) >>> FRAC_BITS);
    endfunction

    task automatic build_vector(input int kind);
        elem_t level;
        int    spike;
        level = $random(seed) % 524288;
        spike = ($random(seed) & 32'h7fff_ffff) % TOTAL_ELEMENTS;
        for (int i = 0; i < TOTAL_ELEMENTS; i++) begin
            case (kind)
                KIND_UNIFORM: vec[i] = level;
                KIND_SPIKE:   vec[i] = (i == spike) ? 32'sh0008_0000 : $random(seed) % 65536;
                KIND_LOW:     vec[i] = -524288 + ($random(seed) & 32'h3ffff);
                default:      vec[i] = $random(seed) % 524288;
            endcase
        end
    endtask

    // Max, exp sum, ln of the sum, then exp of the shifted elements
    task automatic compute_model();
        elem_t  max_v;
        elem_t  ln_v;
        longint sum;
        max_v = vec[0];
        for (int i = 1; i < TOTAL_ELEMENTS; i++) begin
            if (vec[i] > max_v) begin
                max_v = vec[i];
            end
        end
        sum = 0;
        for (int i = 0; i < TOTAL_ELEMENTS; i++) begin
            sum = sum + longint'(exp_ref(vec[i] - max_v));
        end
        ln_v = ln_ref(sum);
        for (int i = 0; i < TOTAL_ELEMENTS; i++) begin
            exp_y[i] = exp_ref(vec[i] - max_v - ln_v);
        end
    endtask

    function automatic tile_t pack_tile(input int t);
        tile_t tile;
        for (int i = 0; i < TILE_SIZE; i++) begin
            tile[(TILE_SIZE-1-i)*ELEM_W +: ELEM_W] = vec[t*TILE_SIZE + i];  // Element 0 on top
        end
        pack_tile = tile;
    endfunction

    function automatic tile_t random_tile();
        tile_t tile;
        for (int i = 0; i < TILE_SIZE; i++) begin
            tile[i*ELEM_W +: ELEM_W] = $random(seed);
        end
        random_tile = tile;
    endfunction

    task automatic check_flag(input string name, input logic got, input logic expv);
        assert (got === expv) else begin
            $display("** Error at %0t ns: %s expected %b got %b", $time, name, expv, got);
            err_cnt++;
        end
    endtask

    task automatic compare_word(input int idx, input elem_t got, input elem_t expv);
        assert (got === expv) else begin
            $display("** Error at %0t ns: y_tile element %0d expected %h got %h",
                     $time, idx, expv, got);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt == errs_before) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", tests_run, name, err_cnt - errs_before);
        end
    endtask

    // Loads vec with optional gaps and stray tiles, then checks the output stream and done
    task automatic run_vector(input int gap_mask, input int strays);
        int got;
        int g;
        compute_model();
        for (int s = 0; s < strays; s++) begin
            @(posedge clk);
            x_valid <= 1'b1;
            x_tile  <= random_tile();
        end
        @(posedge clk);
        start <= 1'b1;
        for (int t = 0; t < TILES; t++) begin
            g = $random(seed) & gap_mask;
            repeat (g) begin
                @(posedge clk);
                start   <= 1'b0;
                x_valid <= 1'b0;
            end
            @(posedge clk);
            start   <= 1'b0;
            x_valid <= 1'b1;
            x_tile  <= pack_tile(t);
        end
        for (int s = 0; s < strays; s++) begin
            @(posedge clk);
            x_valid <= 1'b1;
            x_tile  <= random_tile();                   // Stray tiles while the buffer is read
        end
        @(posedge clk);
        x_valid <= 1'b0;
        got = 0;
        while (got < TILES) begin
            @(negedge clk);
            if (got > 0) begin
                check_flag("y_valid", y_valid, 1'b1);   // Tiles come out back to back
            end
            if (y_valid) begin
                check_flag("done", done, 1'b0);
                for (int i = 0; i < TILE_SIZE; i++) begin
                    compare_word(got*TILE_SIZE + i, y_tile[(TILE_SIZE-1-i)*ELEM_W +: ELEM_W],
                                 exp_y[got*TILE_SIZE + i]);
                end
                got++;
            end
        end
        @(negedge clk);
        check_flag("done", done, 1'b1);
        repeat (4) begin
            @(negedge clk);
            check_flag("done", done, 1'b1);
            check_flag("y_valid", y_valid, 1'b0);           // No extra tiles
        end
    endtask

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped: timeout after %0d cycles without finishing", cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int errs;
        seed         = 32'hf4cc_d3bd;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        start        = 1'b0;
        x_valid      = 1'b0;
        x_tile       = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        errs = err_cnt;
        repeat (10) begin
            @(negedge clk);
            check_flag("y_valid", y_valid, 1'b0);
            check_flag("done", done, 1'b0);
        end
        report_test("idle after reset", errs);

        errs = err_cnt;
        build_vector(KIND_RANDOM);
        run_vector(0, 0);
        report_test("random vector", errs);

        errs = err_cnt;
        build_vector(KIND_RANDOM);
        run_vector(3, 3);
        report_test("input gaps and stray tiles", errs);

        errs = err_cnt;
        build_vector(KIND_UNIFORM);
        run_vector(0, 0);
        build_vector(KIND_SPIKE);
        run_vector(1, 0);
        report_test("uniform and spike vectors", errs);

        errs = err_cnt;
        build_vector(KIND_RANDOM);
        run_vector(0, 0);
        build_vector(KIND_LOW);                 // Lower max than the run before
        run_vector(1, 0);
        report_test("done hold and restart", errs);

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, err_cnt);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
softmax_pkg.sv
tile_stream_if.sv
softmax_ctrl.sv
exp_lane.sv
softmax_drain.sv
softmax_top.sv
tb_softmax.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the softmax testbench with Verilator, runs it and checks the result
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_softmax; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_softmax)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "SIMULATION PASSED" <<< "$output"; then
    exit 0
fi
exit 1
